//--- src/trace_pkg.sv
////////////////////
// trace unit shared definitions
// widths, depths and vector types for the pipeline tracer
////////////////////

package trace_pkg;

    // pipeline shape
    // fetch, decode, execute, memory, write-back
    localparam int NUM_STAGES   = 5;
    // last stage retires the instruction
    localparam int WB_STAGE     = NUM_STAGES - 1;
    // leading stages that a flush kills (fetch and decode)
    localparam int FLUSH_STAGES = 2;

    // field widths
    localparam int ID_W    = 8;
    localparam int TAG_W   = 8;
    localparam int STAMP_W = 16;

    // record memory
    // one entry per id, addressed by the low id bits
    localparam int TRACE_DEPTH = 16;
    localparam int IDX_W       = 4;

    // instruction id, wraps at 8 bits
    typedef logic [ID_W-1:0]    id_t;
    // per-stage event code
    typedef logic [TAG_W-1:0]   tag_t;
    // free-running cycle count
    typedef logic [STAMP_W-1:0] stamp_t;
    // record entry index
    typedef logic [IDX_W-1:0]   idx_t;

endpackage

//--- src/trace_issuer.sv
////////////////////
// trace issuer
// gives ids to fetched instructions and counts cycles
////////////////////

`timescale 1ns/1ps

module trace_issuer import trace_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   fetch_valid,
    input  logic   stall,
    output logic   issue_valid,
    output id_t    issue_id,
    output stamp_t cycle
);

    // id given to the next fetch
    id_t next_id;

    // issue register
    // the offer stays put while a stall keeps the fetch slot from taking it
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
            next_id     <= '0;
        end else if (!stall) begin
            issue_valid <= fetch_valid;
            if (fetch_valid) begin
                next_id <= next_id + 1'b1;
            end
        end
    end

    // id payload follows the valid bit
    always_ff @(posedge clk) begin
        if (!stall) begin
            issue_id <= next_id;
        end
    end

    // cycle stamp
    // zero in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // an issue is taken by the fetch slot when not stalled
    logic issue_take;
    logic take_seen;
    id_t  last_take_id;

    assign issue_take = issue_valid && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            take_seen <= 1'b0;
        end else if (issue_take) begin
            take_seen    <= 1'b1;
        end
        if (issue_take) begin
            last_take_id <= issue_id;
        end
    end

    // successive taken ids step by exactly one
    a_issue_step : assert property (@(posedge clk) disable iff (rst)
        (issue_take && take_seen) |-> (issue_id == id_t'(last_take_id + 1'b1)));

endmodule

//--- src/stage_slot.sv
////////////////////
// stage slot
// tracks one stage's id, flags first arrival for the record write
////////////////////

`timescale 1ns/1ps

module stage_slot import trace_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   hold,
    input  logic   kill,
    input  logic   in_valid,
    input  id_t    in_id,
    input  tag_t   tag,
    input  stamp_t stamp,
    output logic   pass_valid,
    output id_t    pass_id,
    output logic   wr_en,
    output id_t    wr_id,
    output tag_t   wr_tag,
    output stamp_t wr_stamp
);

    logic valid;
    // set only in the first cycle an item sits here
    logic fresh;
    id_t  id;

    // control state
    // kill beats hold, hold beats load
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            fresh <= 1'b0;
        end else if (kill) begin
            valid <= 1'b0;
            fresh <= 1'b0;
        end else if (hold) begin
            // same item stays, it was already recorded
            fresh <= 1'b0;
        end else begin
            valid <= in_valid;
            fresh <= in_valid;
        end
    end

    // id payload
    always_ff @(posedge clk) begin
        if (!hold) begin
            id <= in_id;
        end
    end

    // downstream sees nothing while held or killed
    // a bubble goes down in that case
    assign pass_valid = valid && !hold && !kill;
    assign pass_id    = id;

    // record write, tag and stamp are live this cycle
    assign wr_en    = valid && fresh;
    assign wr_id    = id;
    assign wr_tag   = tag;
    assign wr_stamp = stamp;

    ////////////////////
    // checks
    ////////////////////

    // a held slot keeps both its item and its occupancy
    a_hold_keeps : assert property (@(posedge clk) disable iff (rst)
        (hold && !kill) |=> ($stable(id) && $stable(valid) && !fresh));

endmodule

//--- src/trace_collector.sv
////////////////////
// trace collector
// per-id stage records, completion record out on write-back
////////////////////

`timescale 1ns/1ps

module trace_collector import trace_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic   [NUM_STAGES-1:0]  wr_en,
    input  id_t    [NUM_STAGES-1:0]  wr_id,
    input  tag_t   [NUM_STAGES-1:0]  wr_tag,
    input  stamp_t [NUM_STAGES-1:0]  wr_stamp,
    output logic                     rec_valid,
    output id_t                      rec_id,
    output tag_t   [NUM_STAGES-1:0]  rec_tag,
    output stamp_t [NUM_STAGES-1:0]  rec_stamp
);

    // one column per stage up to memory
    // write-back values are taken live
    tag_t   tag_mem   [WB_STAGE][TRACE_DEPTH];
    stamp_t stamp_mem [WB_STAGE][TRACE_DEPTH];

    // entry holds an instruction that has not retired
    logic [TRACE_DEPTH-1:0] open_q;

    // entry index of each stage's write
    idx_t [NUM_STAGES-1:0] wr_idx;

    always_comb begin
        for (int k = 0; k < NUM_STAGES; k++) begin
            wr_idx[k] = wr_id[k][IDX_W-1:0];
        end
    end

    ////////////////////
    // record storage
    ////////////////////

    always_ff @(posedge clk) begin
        for (int k = 0; k < WB_STAGE; k++) begin
            if (wr_en[k]) begin
                tag_mem[k][wr_idx[k]]   <= wr_tag[k];
                stamp_mem[k][wr_idx[k]] <= wr_stamp[k];
            end
        end
    end

    // open bits
    // retire clears first so a fetch to the same entry wins
    always_ff @(posedge clk) begin
        if (rst) begin
            open_q <= '0;
        end else begin
            if (wr_en[WB_STAGE]) begin
                open_q[wr_idx[WB_STAGE]] <= 1'b0;
            end
            if (wr_en[0]) begin
                open_q[wr_idx[0]] <= 1'b1;
            end
        end
    end

    ////////////////////
    // completion record
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= wr_en[WB_STAGE];
        end
    end

    // stored columns plus the live write-back pair
    always_ff @(posedge clk) begin
        if (wr_en[WB_STAGE]) begin
            rec_id <= wr_id[WB_STAGE];
            for (int k = 0; k < WB_STAGE; k++) begin
                rec_tag[k]   <= tag_mem[k][wr_idx[WB_STAGE]];
                rec_stamp[k] <= stamp_mem[k][wr_idx[WB_STAGE]];
            end
            rec_tag[WB_STAGE]   <= wr_tag[WB_STAGE];
            rec_stamp[WB_STAGE] <= wr_stamp[WB_STAGE];
        end
    end

    ////////////////////
    // checks
    ////////////////////

    logic ret_seen;
    id_t  last_ret_id;
    id_t  ret_step;

    always_ff @(posedge clk) begin
        if (rst) begin
            ret_seen <= 1'b0;
        end else if (wr_en[WB_STAGE]) begin
            ret_seen <= 1'b1;
        end
        if (wr_en[WB_STAGE]) begin
            last_ret_id <= wr_id[WB_STAGE];
        end
    end

    // forward distance from the last retired id, modulo wrap
    assign ret_step = wr_id[WB_STAGE] - last_ret_id;

    // retire only what was fetched and not yet retired
    a_wb_open : assert property (@(posedge clk) disable iff (rst)
        wr_en[WB_STAGE] |-> open_q[wr_idx[WB_STAGE]]);

    // in-order retire, flushed ids may leave gaps
    a_ret_order : assert property (@(posedge clk) disable iff (rst)
        (wr_en[WB_STAGE] && ret_seen) |-> (ret_step != '0 && !ret_step[ID_W-1]));

endmodule

//--- src/pipeline_trace.sv
////////////////////
// pipeline trace top
// issuer, chained stage slots and record collector
////////////////////

`timescale 1ns/1ps

module pipeline_trace import trace_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fetch_valid,
    input  logic                    stall,
    input  logic                    flush,
    input  tag_t   [NUM_STAGES-1:0] stage_tag,
    output logic                    rec_valid,
    output id_t                     rec_id,
    output tag_t   [NUM_STAGES-1:0] rec_tag,
    output stamp_t [NUM_STAGES-1:0] rec_stamp
);

    // slot inputs, entry 0 comes from the issuer
    logic   [NUM_STAGES-1:0] slot_in_valid;
    id_t    [NUM_STAGES-1:0] slot_in_id;
    stamp_t                  cycle;

    // slot write ports into the collector
    logic   [NUM_STAGES-1:0] wr_en;
    id_t    [NUM_STAGES-1:0] wr_id;
    tag_t   [NUM_STAGES-1:0] wr_tag;
    stamp_t [NUM_STAGES-1:0] wr_stamp;

    trace_issuer u_issuer (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .issue_valid (slot_in_valid[0]),
        .issue_id    (slot_in_id[0]),
        .cycle       (cycle)
    );

    ////////////////////
    // stage chain
    ////////////////////

    // fetch and decode see stall and flush, later stages never stop
    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_slot
        if (k < NUM_STAGES - 1) begin : g_mid
            stage_slot u_slot (
                .clk        (clk),
                .rst        (rst),
                .hold       ((k < FLUSH_STAGES) ? stall : 1'b0),
                .kill       ((k < FLUSH_STAGES) ? flush : 1'b0),
                .in_valid   (slot_in_valid[k]),
                .in_id      (slot_in_id[k]),
                .tag        (stage_tag[k]),
                .stamp      (cycle),
                .pass_valid (slot_in_valid[k+1]),
                .pass_id    (slot_in_id[k+1]),
                .wr_en      (wr_en[k]),
                .wr_id      (wr_id[k]),
                .wr_tag     (wr_tag[k]),
                .wr_stamp   (wr_stamp[k])
            );
        end else begin : g_last
            // write-back only reports to the collector
            stage_slot u_slot (
                .clk        (clk),
                .rst        (rst),
                .hold       (1'b0),
                .kill       (1'b0),
                .in_valid   (slot_in_valid[k]),
                .in_id      (slot_in_id[k]),
                .tag        (stage_tag[k]),
                .stamp      (cycle),
                .pass_valid (),
                .pass_id    (),
                .wr_en      (wr_en[k]),
                .wr_id      (wr_id[k]),
                .wr_tag     (wr_tag[k]),
                .wr_stamp   (wr_stamp[k])
            );
        end
    end

    trace_collector u_collector (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_id     (wr_id),
        .wr_tag    (wr_tag),
        .wr_stamp  (wr_stamp),
        .rec_valid (rec_valid),
        .rec_id    (rec_id),
        .rec_tag   (rec_tag),
        .rec_stamp (rec_stamp)
    );

endmodule

//--- verif/tb_pipeline_trace.sv
////////////////////
// pipeline trace testbench
// directed tests checked against a log of the driven stage tags
////////////////////

`timescale 1ns/1ps

module tb_pipeline_trace import trace_pkg::*; ();

    // one completion record as seen on the top outputs
    typedef struct packed {
        id_t                     id;
        int                      seen;
        tag_t   [NUM_STAGES-1:0] tag;
        stamp_t [NUM_STAGES-1:0] stamp;
    } rec_t;

    logic                    clk;
    logic                    rst;
    logic                    fetch_valid;
    logic                    stall;
    logic                    flush;
    tag_t   [NUM_STAGES-1:0] stage_tag;
    logic                    rec_valid;
    id_t                     rec_id;
    tag_t   [NUM_STAGES-1:0] rec_tag;
    stamp_t [NUM_STAGES-1:0] rec_stamp;

    // cycle count that is zero in the first cycle out of reset like the stamp
    int                    tb_cycle;
    // tags driven per cycle by the low bits of the count
    tag_t [NUM_STAGES-1:0] tag_log [4096];
    rec_t                  rec_q [$];
    rec_t                  mon_rec;
    // id the issuer hands out next
    id_t                   exp_id;
    int                    test_errs;
    int                    tests_run;
    int                    tests_failed;

    pipeline_trace DUT (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .flush       (flush),
        .stage_tag   (stage_tag),
        .rec_valid   (rec_valid),
        .rec_id      (rec_id),
        .rec_tag     (rec_tag),
        .rec_stamp   (rec_stamp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) begin
            tb_cycle <= 0;
        end else begin
            tb_cycle <= tb_cycle + 1;
        end
    end

    // random tags each falling edge logged under the current cycle
    initial begin
        void'($urandom(32'ha1ab_cc22));
        stage_tag = '0;
        forever begin
            @(negedge clk);
            for (int k = 0; k < NUM_STAGES; k++) begin
                stage_tag[k] = tag_t'($urandom);
            end
            tag_log[tb_cycle[11:0]] = stage_tag;
        end
    end

    // record monitor samples the settled outputs mid-cycle
    always @(negedge clk) begin
        if (rec_valid === 1'b1) begin
            mon_rec.id    = rec_id;
            mon_rec.seen  = tb_cycle;
            mon_rec.tag   = rec_tag;
            mon_rec.stamp = rec_stamp;
            rec_q.push_back(mon_rec);
        end
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic mismatch(input string test, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED %s %s: expected %0h, actual %0h", test, what, exp, act);
        test_errs++;
    endtask

    task automatic problem(input string test, input string what);
        $display("%s: %s", test, what);
        test_errs++;
    endtask

    task automatic end_test(input string test);
        tests_run++;
        if (test_errs == 0) begin
            $display("%s: passed", test);
        end else begin
            $display("%s: failed with %0d errors", test, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // wait for count records and then watch a quiet window for strays
    task automatic wait_records(input string test, input int count);
        int waited;
        waited = 0;
        while (rec_q.size() < count && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (rec_q.size() < count) begin
            problem(test, $sformatf("timed out with %0d of %0d records", rec_q.size(), count));
        end
        repeat (10) @(negedge clk);
        if (rec_q.size() > count) begin
            problem(test, $sformatf("%0d records arrived, expected %0d", rec_q.size(), count));
        end
    endtask

    // checks id and log tags and one-cycle steps above stage first
    task automatic check_record(input string test, input rec_t r, input id_t id,
                                input int first);
        stamp_t s;
        if (r.id !== id) begin
            mismatch(test, "rec_id", 32'(id), 32'(r.id));
        end
        for (int k = 0; k < NUM_STAGES; k++) begin
            s = r.stamp[k];
            if (r.tag[k] !== tag_log[s[11:0]][k]) begin
                mismatch(test, $sformatf("tag %0d", k), 32'(tag_log[s[11:0]][k]),
                         32'(r.tag[k]));
            end
            if (k > first && r.stamp[k] !== stamp_t'(r.stamp[k-1] + 1'b1)) begin
                mismatch(test, $sformatf("stamp %0d", k), 32'(r.stamp[k-1]) + 1,
                         32'(r.stamp[k]));
            end
        end
        // record shows the cycle after the write-back write
        if (r.seen != int'(r.stamp[WB_STAGE]) + 1) begin
            mismatch(test, "record cycle", 32'(r.stamp[WB_STAGE]) + 1, 32'(r.seen));
        end
    endtask

    // n fetches on consecutive cycles starting in first_cycle
    task automatic fetch_burst(input int n, output int first_cycle);
        @(negedge clk);
        first_cycle = tb_cycle;
        fetch_valid = 1'b1;
        repeat (n - 1) @(negedge clk);
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_reset_quiet();
        rst = 1'b1;
        repeat (5) begin
            @(negedge clk);
            if (rec_valid !== 1'b0) begin
                mismatch("reset_quiet", "rec_valid in reset", 32'd0, 32'(rec_valid));
            end
        end
        rst = 1'b0;
        repeat (10) begin
            @(negedge clk);
            if (rec_valid !== 1'b0) begin
                mismatch("reset_quiet", "rec_valid idle", 32'd0, 32'(rec_valid));
            end
        end
        end_test("reset_quiet");
    endtask

    task automatic test_single();
        int c;
        rec_q.delete();
        fetch_burst(1, c);
        wait_records("single", 1);
        if (rec_q.size() >= 1) begin
            check_record("single", rec_q[0], exp_id, 0);
            // sampled at the edge ending cycle c so six edges on is cycle c + 7
            if (rec_q[0].seen != c + 7) begin
                mismatch("single", "record cycle", 32'(c + 7), 32'(rec_q[0].seen));
            end
            // one edge into the issue register and one into fetch
            if (rec_q[0].stamp[0] !== stamp_t'(c + 2)) begin
                mismatch("single", "fetch stamp", 32'(c + 2), 32'(rec_q[0].stamp[0]));
            end
        end
        exp_id = id_t'(exp_id + 1);
        end_test("single");
    endtask

    task automatic test_stream();
        int c;
        rec_q.delete();
        fetch_burst(12, c);
        wait_records("stream", 12);
        for (int i = 0; i < rec_q.size(); i++) begin
            check_record("stream", rec_q[i], id_t'(exp_id + i), 0);
            if (rec_q[i].stamp[0] !== stamp_t'(c + 2 + i)) begin
                mismatch("stream", "fetch stamp", 32'(c + 2 + i), 32'(rec_q[i].stamp[0]));
            end
        end
        exp_id = id_t'(exp_id + 12);
        end_test("stream");
    endtask

    task automatic test_stall();
        int c;
        int s;
        int exp_s;
        s = 3;
        rec_q.delete();
        @(negedge clk);
        c = tb_cycle;
        fetch_valid = 1'b1;
        repeat (2) @(negedge clk);
        // first fetch sits in decode from cycle c + 3 while fetch stays requested
        @(negedge clk);
        stall = 1'b1;
        repeat (s - 1) @(negedge clk);
        @(negedge clk);
        stall = 1'b0;
        fetch_valid = 1'b0;
        // only the three unstalled fetch cycles issue
        wait_records("stall", 3);
        for (int i = 0; i < rec_q.size(); i++) begin
            check_record("stall", rec_q[i], id_t'(exp_id + i), FLUSH_STAGES);
            // the third issue waits out the stall in the issue register
            exp_s = c + 2 + i + ((i == 2) ? s : 0);
            if (rec_q[i].stamp[0] !== stamp_t'(exp_s)) begin
                mismatch("stall", "fetch stamp", 32'(exp_s), 32'(rec_q[i].stamp[0]));
            end
        end
        if (rec_q.size() >= 1) begin
            if (rec_q[0].stamp[1] !== stamp_t'(c + 3)) begin
                mismatch("stall", "decode stamp", 32'(c + 3), 32'(rec_q[0].stamp[1]));
            end
            if (rec_q[0].stamp[2] - rec_q[0].stamp[1] !== stamp_t'(1 + s)) begin
                mismatch("stall", "execute minus decode", 32'(1 + s),
                         32'(rec_q[0].stamp[2] - rec_q[0].stamp[1]));
            end
        end
        exp_id = id_t'(exp_id + 3);
        end_test("stall");
    endtask

    task automatic test_flush();
        int c;
        int f;
        int keep [$];
        f = 5;
        rec_q.delete();
        @(negedge clk);
        c = tb_cycle;
        fetch_valid = 1'b1;
        // eight fetches with flush high in cycle c + f
        for (int i = 1; i <= 8; i++) begin
            @(negedge clk);
            flush = (i == f);
            fetch_valid = (i < 8);
        end
        // fetch i waits in issue, fetch and decode during cycles c+i+1 .. c+i+3
        for (int i = 0; i < 8; i++) begin
            if (i + 1 > f || i + 3 < f) begin
                keep.push_back(i);
            end
        end
        wait_records("flush", keep.size());
        for (int j = 0; j < rec_q.size() && j < keep.size(); j++) begin
            check_record("flush", rec_q[j], id_t'(exp_id + keep[j]), 0);
            if (rec_q[j].stamp[0] !== stamp_t'(c + 2 + keep[j])) begin
                mismatch("flush", "fetch stamp", 32'(c + 2 + keep[j]),
                         32'(rec_q[j].stamp[0]));
            end
        end
        exp_id = id_t'(exp_id + 8);
        end_test("flush");
    endtask

    initial begin
        rst          = 1'b1;
        fetch_valid  = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        exp_id       = '0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_reset_quiet();
        test_single();
        test_stall();
        test_flush();
        // the stream ids run past TRACE_DEPTH from here
        test_stream();
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- list.f
src/trace_pkg.sv
src/trace_issuer.sv
src/stage_slot.sv
src/trace_collector.sv
src/pipeline_trace.sv
verif/tb_pipeline_trace.sv

//--- run.sh
#!/bin/sh
# build the pipeline trace testbench with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_pipeline_trace -Mdir obj_dir -o tb_pipeline_trace

./obj_dir/tb_pipeline_trace > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "simulation ended without a result, see sim.log"
    exit 1
fi
echo "simulation clean"
